// File: Makefile
# Verilator build and run for the fetch buffer testbench

VERILATOR ?= verilator
TOP       ?= fetch_buffer_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation finished without failures"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/fetch_buffer_sva.sv
`timescale 1ns/1ps

module fetch_buffer_sva #(
  parameter int BUFFER_DEPTH = 8
) (
  input logic                          clock,
  input logic                          reset,
  input logic                          flush,
  input logic                          fetch_ready,
  input logic                          issue_stall,
  input logic                          slot0_valid,
  input logic                          slot1_valid,
  input logic [$clog2(BUFFER_DEPTH)+2:0] count
);

  localparam int CAPACITY = 4 * BUFFER_DEPTH;

  typedef logic [$clog2(BUFFER_DEPTH)+2:0] count_t;

  // Read by the testbench summary
  int failures = 0;

  slot1_needs_slot0: assert property (@(posedge clock) disable iff (!reset)
    slot1_valid |-> slot0_valid)
  else begin
    $error("slot1_valid is high while slot0_valid is low");
    failures++;
  end

  no_ready_in_flush: assert property (@(posedge clock) disable iff (!reset)
    flush |-> !fetch_ready)
  else begin
    $error("fetch_ready is high in a flush cycle");
    failures++;
  end

  occupancy_in_range: assert property (@(posedge clock) disable iff (!reset)
    count <= count_t'(CAPACITY))
  else begin
    $error("occupancy %0d exceeds the buffer capacity", count);
    failures++;
  end

  no_issue_under_stall: assert property (@(posedge clock) disable iff (!reset)
    issue_stall |-> !slot0_valid && !slot1_valid)
  else begin
    $error("a slot is valid while issue_stall is high");
    failures++;
  end

endmodule

bind fetch_align_ctrl fetch_buffer_sva #(
  .BUFFER_DEPTH(BUFFER_DEPTH)
) sva0 (
  .clock(clock),
  .reset(reset),
  .flush(flush),
  .fetch_ready(fetch_ready),
  .issue_stall(issue_stall),
  .slot0_valid(slot0_valid),
  .slot1_valid(slot1_valid),
  .count(count)
);

// File: tests/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb;

  localparam int BUFFER_DEPTH = 8;
  localparam int ALIGNED_PACKETS = 8;
  localparam int MIXED_PACKETS = 16;
  localparam int STALE_PACKETS = 2;
  localparam int REDIRECT_PACKETS = 6;
  localparam int STALL_PACKETS = 12;
  localparam int TOTAL_PACKETS = ALIGNED_PACKETS + MIXED_PACKETS + STALE_PACKETS
                                 + REDIRECT_PACKETS + STALL_PACKETS;
  // Twenty cycles per packet, plus reset and drain time
  localparam int WATCHDOG_CYCLES = TOTAL_PACKETS * 20 + 100;

  logic               clock = 1'b0;
  logic               reset;
  logic               fetch_valid;
  fetch_pkg::addr_t   fetch_pc;
  fetch_pkg::packet_t fetch_data;
  logic               fetch_ready;
  logic               flush;
  logic               issue_stall;
  logic               slot0_valid;
  fetch_pkg::addr_t   slot0_pc;
  fetch_pkg::instr_t  slot0_instr;
  logic               slot1_valid;
  fetch_pkg::addr_t   slot1_pc;
  fetch_pkg::instr_t  slot1_instr;

  logic [31:0]        rng = 32'h23ea15de;
  int                 errors = 0;
  int                 checks = 0;
  logic               watch_first = 1'b0;
  fetch_pkg::addr_t   first_pc;

  // Packets still to send, and instructions still to see issued
  fetch_pkg::addr_t   pkt_pc [$];
  fetch_pkg::packet_t pkt_data [$];
  fetch_pkg::addr_t   exp_pc [$];
  fetch_pkg::instr_t  exp_instr [$];

  fetch_buffer dut0 (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .fetch_ready(fetch_ready),
    .flush(flush),
    .issue_stall(issue_stall),
    .slot0_valid(slot0_valid),
    .slot0_pc(slot0_pc),
    .slot0_instr(slot0_instr),
    .slot1_valid(slot1_valid),
    .slot1_pc(slot1_pc),
    .slot1_instr(slot1_instr)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t ns: %s", $time, msg);
  endtask

  // Instruction list from start_pc, packed into whole packets
  task automatic build_stream(input fetch_pkg::addr_t start_pc, input int packets,
                              input bit mixed);
    fetch_pkg::parcel_t parcels [$];
    fetch_pkg::parcel_t lo;
    fetch_pkg::parcel_t hi;
    fetch_pkg::packet_t data;
    fetch_pkg::addr_t   pc;
    int                 offset;
    int                 total;
    int                 idx;
    offset = int'(start_pc[2:1]);
    total = packets * 4 - offset;
    pc = start_pc;
    while (parcels.size() < total) begin
      rng = xorshift32(rng);
      if ((!mixed || rng[0]) && total - parcels.size() >= 2) begin
        lo = {rng[15:2], 2'b11};
        rng = xorshift32(rng);
        hi = rng[31:16];
        parcels.push_back(lo);
        parcels.push_back(hi);
        exp_pc.push_back(pc);
        exp_instr.push_back({hi, lo});
        pc = pc + 32'd4;
      end else begin
        lo[15:2] = rng[15:2];
        lo[1:0] = (rng[17:16] == 2'b11) ? 2'b01 : rng[17:16];
        parcels.push_back(lo);
        exp_pc.push_back(pc);
        exp_instr.push_back({16'h0000, lo});
        pc = pc + 32'd2;
      end
    end
    for (int k = 0; k < packets; k++) begin
      for (int b = 0; b < 4; b++) begin
        idx = k * 4 + b - offset;
        rng = xorshift32(rng);
        // Parcels in front of the target are filler
        data[16*b +: 16] = (idx < 0) ? rng[15:0] : parcels[idx];
      end
      pkt_pc.push_back((k == 0) ? start_pc : {start_pc[31:3], 3'b000} + 32'(8 * k));
      pkt_data.push_back(data);
    end
  endtask

  task automatic send_packets();
    logic accepted;
    while (pkt_pc.size() > 0) begin
      fetch_valid = 1'b1;
      fetch_pc = pkt_pc[0];
      fetch_data = pkt_data[0];
      @(negedge clock);
      accepted = fetch_ready;
      @(posedge clock);
      #1;
      if (accepted) begin
        void'(pkt_pc.pop_front());
        void'(pkt_data.pop_front());
      end
    end
    fetch_valid = 1'b0;
  endtask

  task automatic wait_drain(input string test_name);
    int cycles;
    cycles = 0;
    while (exp_pc.size() > 0 && cycles < 400) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (exp_pc.size() > 0) begin
      report_failure($sformatf("%s: %0d instructions were never issued",
                               test_name, exp_pc.size()));
      exp_pc.delete();
      exp_instr.delete();
    end
  endtask

  task automatic compare_slot(input string slot, input fetch_pkg::addr_t pc,
                              input fetch_pkg::instr_t instr);
    if (exp_pc.size() == 0) begin
      report_failure($sformatf("%s issued pc %h with no instruction expected", slot, pc));
    end else begin
      check_value({slot, "_pc"}, pc, exp_pc.pop_front());
      check_value({slot, "_instr"}, instr, exp_instr.pop_front());
    end
  endtask

  // Slots are sampled mid-cycle, slot0 before slot1
  always @(negedge clock) begin
    if (reset) begin
      if (slot1_valid && !slot0_valid) begin
        report_failure("slot1_valid is high while slot0_valid is low");
      end
      if (slot0_valid) begin
        if (watch_first) begin
          first_pc = slot0_pc;
          watch_first = 1'b0;
        end
        compare_slot("slot0", slot0_pc, slot0_instr);
      end
      if (slot1_valid) begin
        compare_slot("slot1", slot1_pc, slot1_instr);
      end
    end
  end

  task automatic test_reset_state();
    @(negedge clock);
    check_value("slot0_valid", 32'(slot0_valid), 32'd0);
    check_value("slot1_valid", 32'(slot1_valid), 32'd0);
    check_value("fetch_ready", 32'(fetch_ready), 32'd1);
    @(posedge clock);
    #1;
  endtask

  task automatic test_aligned_stream();
    build_stream(32'h0000_1000, ALIGNED_PACKETS, 1'b0);
    send_packets();
    wait_drain("aligned stream");
  endtask

  task automatic test_mixed_stream();
    build_stream(32'h0000_2000, MIXED_PACKETS, 1'b1);
    send_packets();
    wait_drain("mixed stream");
  endtask

  task automatic test_redirect();
    fetch_pkg::packet_t stale;
    issue_stall = 1'b1;
    for (int k = 0; k < STALE_PACKETS; k++) begin
      rng = xorshift32(rng);
      stale = {rng, ~rng};
      pkt_pc.push_back(32'h0000_3000 + 32'(8 * k));
      pkt_data.push_back(stale);
    end
    send_packets();
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
    // Target sits at parcel 2 of its packet
    build_stream(32'h0000_4004, REDIRECT_PACKETS, 1'b1);
    watch_first = 1'b1;
    issue_stall = 1'b0;
    send_packets();
    wait_drain("redirect");
    check_value("first_slot0_pc", first_pc, 32'h0000_4004);
  endtask

  task automatic test_stall_fill();
    int accepted;
    bit ready_fell;
    accepted = 0;
    ready_fell = 1'b0;
    issue_stall = 1'b1;
    build_stream(32'h0000_5000, STALL_PACKETS, 1'b1);
    while (!ready_fell && pkt_pc.size() > 0) begin
      fetch_valid = 1'b1;
      fetch_pc = pkt_pc[0];
      fetch_data = pkt_data[0];
      @(negedge clock);
      if (fetch_ready) begin
        accepted++;
      end else begin
        ready_fell = 1'b1;
      end
      @(posedge clock);
      #1;
      if (!ready_fell) begin
        void'(pkt_pc.pop_front());
        void'(pkt_data.pop_front());
      end
    end
    check_value("accepted_packets", accepted, BUFFER_DEPTH);
    issue_stall = 1'b0;
    send_packets();
    wait_drain("stall fill");
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    flush = 1'b0;
    issue_stall = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
    test_reset_state();
    test_aligned_stream();
    test_mixed_stream();
    test_redirect();
    test_stall_fill();
    errors += dut0.align_ctrl0.sva0.failures;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/fetch_pkg.sv
verilog/fetch_bank_if.sv
verilog/fetch_bank_array.sv
verilog/fetch_align_ctrl.sv
verilog/fetch_buffer.sv
tests/fetch_buffer_sva.sv
tests/fetch_buffer_tb.sv

// File: verilog/fetch_align_ctrl.sv
`timescale 1ns/1ps

module fetch_align_ctrl #(
  parameter int BUFFER_DEPTH = 8
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                fetch_valid,
  input  fetch_pkg::addr_t    fetch_pc,
  input  fetch_pkg::packet_t  fetch_data,
  output logic                fetch_ready,
  input  logic                flush,
  input  logic                issue_stall,
  output logic                slot0_valid,
  output fetch_pkg::addr_t    slot0_pc,
  output fetch_pkg::instr_t   slot0_instr,
  output logic                slot1_valid,
  output fetch_pkg::addr_t    slot1_pc,
  output fetch_pkg::instr_t   slot1_instr,
  fetch_bank_if.ctrl          banks
);

  localparam int INDEX_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int PARCELS = fetch_pkg::PACKET_PARCELS;
  localparam int CAPACITY = PARCELS * BUFFER_DEPTH;

  typedef logic [INDEX_WIDTH-1:0] row_t;
  // Parcel pointer with the row in the upper bits and the bank in the low two
  typedef logic [INDEX_WIDTH+1:0] ptr_t;
  typedef logic [INDEX_WIDTH+2:0] count_t;

  fetch_pkg::align_state_t state;
  ptr_t                    wptr;
  ptr_t                    rptr;
  count_t                  count;

  logic                    wen;
  logic [1:0]              target_offset;
  ptr_t                    read_ptr;
  row_t                    read_row;
  logic [1:0]              read_offset;
  count_t                  added;
  count_t                  avail;
  fetch_pkg::entry_t       wdata [PARCELS];
  fetch_pkg::entry_t       bank_data [PARCELS];
  fetch_pkg::entry_t       window [PARCELS];
  row_t                    raddr [PARCELS];
  logic [PARCELS-1:0]      comp;
  logic [2:0]              len0;
  logic [2:0]              len1;
  fetch_pkg::entry_t       first1;
  fetch_pkg::entry_t       next1;
  logic                    slot0_ok;
  logic                    slot1_ok;
  logic [2:0]              consumed;

  // Room for one more whole packet is required
  assign fetch_ready = !flush && !(count > count_t'(CAPACITY - PARCELS));
  assign wen = fetch_valid && fetch_ready;
  assign target_offset = fetch_pc[2:1];

  always_comb begin
    for (int b = 0; b < PARCELS; b++) begin
      wdata[b] = {fetch_pc[31:3], 2'(b), 1'b0, fetch_data[16*b +: 16]};
    end
  end

  assign banks.wen = wen;
  assign banks.waddr = wptr[INDEX_WIDTH+1:2];
  assign banks.wdata0 = wdata[0];
  assign banks.wdata1 = wdata[1];
  assign banks.wdata2 = wdata[2];
  assign banks.wdata3 = wdata[3];

  // First packet after a flush sets where reading starts
  assign read_ptr = (state == fetch_pkg::align_redirect && wen) ? ptr_t'(target_offset) : rptr;
  assign read_row = read_ptr[INDEX_WIDTH+1:2];
  assign read_offset = read_ptr[1:0];

  // Banks below the offset already hold the next row
  always_comb begin
    for (int b = 0; b < PARCELS; b++) begin
      if (2'(b) < read_offset) begin
        raddr[b] = read_row + row_t'(1);
      end else begin
        raddr[b] = read_row;
      end
    end
  end

  assign banks.raddr0 = raddr[0];
  assign banks.raddr1 = raddr[1];
  assign banks.raddr2 = raddr[2];
  assign banks.raddr3 = raddr[3];

  assign bank_data[0] = banks.rdata0;
  assign bank_data[1] = banks.rdata1;
  assign bank_data[2] = banks.rdata2;
  assign bank_data[3] = banks.rdata3;

  // Rotate bank outputs into parcel order
  always_comb begin
    for (int k = 0; k < PARCELS; k++) begin
      window[k] = bank_data[2'(read_offset + 2'(k))];
      comp[k] = window[k][1:0] != 2'b11;
    end
  end

  always_comb begin
    added = '0;
    if (wen) begin
      if (state == fetch_pkg::align_redirect) begin
        added = count_t'(3'd4 - {1'b0, target_offset});
      end else begin
        added = count_t'(PARCELS);
      end
    end
  end

  assign avail = count + added;

  always_comb begin
    slot0_pc = window[0][47:16];
    if (comp[0]) begin
      len0 = 3'd1;
      slot0_instr = {16'b0, window[0][15:0]};
    end else begin
      len0 = 3'd2;
      slot0_instr = {window[1][15:0], window[0][15:0]};
    end
    slot0_ok = avail >= count_t'(len0);

    // Slot1 begins right after slot0's parcels
    first1 = window[len0[1:0]];
    next1 = window[2'(len0 + 3'd1)];
    slot1_pc = first1[47:16];
    if (comp[len0[1:0]]) begin
      len1 = 3'd1;
      slot1_instr = {16'b0, first1[15:0]};
    end else begin
      len1 = 3'd2;
      slot1_instr = {next1[15:0], first1[15:0]};
    end
    slot1_ok = avail >= count_t'(len0 + len1);
  end

  assign slot0_valid = slot0_ok && !issue_stall && !flush;
  assign slot1_valid = slot0_valid && slot1_ok;

  always_comb begin
    if (slot1_valid) begin
      consumed = len0 + len1;
    end else if (slot0_valid) begin
      consumed = len0;
    end else begin
      consumed = 3'd0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::align_normal;
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else if (flush) begin
      state <= fetch_pkg::align_redirect;
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else begin
      if (wen) begin
        wptr <= wptr + ptr_t'(PARCELS);
        state <= fetch_pkg::align_normal;
      end
      rptr <= read_ptr + ptr_t'(consumed);
      count <= avail - count_t'(consumed);
    end
  end

endmodule

// File: verilog/fetch_bank_array.sv
`timescale 1ns/1ps

module fetch_bank_array #(
  parameter int BUFFER_DEPTH = 8
) (
  input logic        clock,
  fetch_bank_if.bank banks
);

  localparam int INDEX_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int BANKS = fetch_pkg::PACKET_PARCELS;

  typedef logic [INDEX_WIDTH-1:0] row_t;

  fetch_pkg::entry_t mem [BANKS][BUFFER_DEPTH];
  fetch_pkg::entry_t wdata [BANKS];
  fetch_pkg::entry_t rdata [BANKS];
  row_t              raddr [BANKS];

  // Per-bank bus signals gathered into arrays
  assign wdata[0] = banks.wdata0;
  assign wdata[1] = banks.wdata1;
  assign wdata[2] = banks.wdata2;
  assign wdata[3] = banks.wdata3;

  assign raddr[0] = banks.raddr0;
  assign raddr[1] = banks.raddr1;
  assign raddr[2] = banks.raddr2;
  assign raddr[3] = banks.raddr3;

  assign banks.rdata0 = rdata[0];
  assign banks.rdata1 = rdata[1];
  assign banks.rdata2 = rdata[2];
  assign banks.rdata3 = rdata[3];

  always_ff @(posedge clock) begin
    if (banks.wen) begin
      for (int b = 0; b < BANKS; b++) begin
        mem[b][banks.waddr] <= wdata[b];
      end
    end
  end

  // A row being written this cycle reads back its new entry
  always_comb begin
    for (int b = 0; b < BANKS; b++) begin
      if (banks.wen && raddr[b] == banks.waddr) begin
        rdata[b] = wdata[b];
      end else begin
        rdata[b] = mem[b][raddr[b]];
      end
    end
  end

endmodule

// File: verilog/fetch_bank_if.sv
`timescale 1ns/1ps

interface fetch_bank_if #(
  parameter int INDEX_WIDTH = 3
);

  // Shared write row for all banks
  logic                   wen;
  logic [INDEX_WIDTH-1:0] waddr;
  fetch_pkg::entry_t      wdata0;
  fetch_pkg::entry_t      wdata1;
  fetch_pkg::entry_t      wdata2;
  fetch_pkg::entry_t      wdata3;

  // Each bank is read at its own row
  logic [INDEX_WIDTH-1:0] raddr0;
  logic [INDEX_WIDTH-1:0] raddr1;
  logic [INDEX_WIDTH-1:0] raddr2;
  logic [INDEX_WIDTH-1:0] raddr3;
  fetch_pkg::entry_t      rdata0;
  fetch_pkg::entry_t      rdata1;
  fetch_pkg::entry_t      rdata2;
  fetch_pkg::entry_t      rdata3;

  modport ctrl (
    output wen, waddr, wdata0, wdata1, wdata2, wdata3,
    output raddr0, raddr1, raddr2, raddr3,
    input  rdata0, rdata1, rdata2, rdata3
  );

  modport bank (
    input  wen, waddr, wdata0, wdata1, wdata2, wdata3,
    input  raddr0, raddr1, raddr2, raddr3,
    output rdata0, rdata1, rdata2, rdata3
  );

endinterface

// File: verilog/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int BUFFER_DEPTH = 8
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                fetch_valid,
  input  fetch_pkg::addr_t    fetch_pc,
  input  fetch_pkg::packet_t  fetch_data,
  output logic                fetch_ready,
  input  logic                flush,
  input  logic                issue_stall,
  output logic                slot0_valid,
  output fetch_pkg::addr_t    slot0_pc,
  output fetch_pkg::instr_t   slot0_instr,
  output logic                slot1_valid,
  output fetch_pkg::addr_t    slot1_pc,
  output fetch_pkg::instr_t   slot1_instr
);

  // Row index width of one bank
  localparam int INDEX_WIDTH = $clog2(BUFFER_DEPTH);

  fetch_bank_if #(
    .INDEX_WIDTH(INDEX_WIDTH)
  ) bank_bus ();

  fetch_align_ctrl #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) align_ctrl0 (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .fetch_ready(fetch_ready),
    .flush(flush),
    .issue_stall(issue_stall),
    .slot0_valid(slot0_valid),
    .slot0_pc(slot0_pc),
    .slot0_instr(slot0_instr),
    .slot1_valid(slot1_valid),
    .slot1_pc(slot1_pc),
    .slot1_instr(slot1_instr),
    .banks(bank_bus.ctrl)
  );

  fetch_bank_array #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) bank_array0 (
    .clock(clock),
    .banks(bank_bus.bank)
  );

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  // One parcel per bank in every fetch packet
  localparam int PACKET_PARCELS = 4;

  // Byte address of a packet or an instruction
  typedef logic [31:0] addr_t;

  // Fetched data, parcel 0 in the low half-word
  typedef logic [63:0] packet_t;

  typedef logic [15:0] parcel_t;

  // Instruction as handed to issue
  typedef logic [31:0] instr_t;

  // Packet address bits 31..3, parcel byte offset, then the parcel
  typedef logic [47:0] entry_t;

  // Redirect waits for the first packet after a flush
  typedef enum logic {
    align_normal,
    align_redirect
  } align_state_t;

endpackage
